/* design/resizer_pixel_pkg.sv */
`default_nettype none

package resizer_pixel_pkg;

   typedef logic [7:0] chan_t;

   typedef struct packed {
      chan_t r;
      chan_t g;
      chan_t b;
   } pixel_t;

   // rows 0 to 3 of one window column
   typedef struct packed {
      pixel_t [3:0] row;
   } col_t;

   // anchor column sits in col[0]
   typedef struct packed {
      col_t [3:0] col;
   } window_t;

   // R in bits 7:0, G in 15:8, B in 23:16, top byte unused
   typedef struct packed {
      logic [31:0] tdata;
   } stream_in_t;

endpackage

`default_nettype wire

/* design/resizer_frame_pkg.sv */
`default_nettype none

package resizer_frame_pkg;

   //////////////////////////////
   // frame geometry
   //////////////////////////////
   localparam int FRAME_W = 16;
   localparam int FRAME_H = 10;
   localparam int WIN     = 4;      // bicubic kernel side

   typedef logic [3:0]          x_t;
   typedef logic [3:0]          y_t;
   typedef logic [1:0]          slot_t;   // line buffer entry, row mod 4
   typedef logic [$bits(y_t):0] rows_t;   // row count up to FRAME_H

   //////////////////////////////
   // control states
   //////////////////////////////
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ACCEPT,
      WR_HOLD
   } wr_state_t;

   typedef enum logic [1:0] {
      RD_WAIT,
      RD_PRIME,
      RD_RUN,
      RD_CLEAR
   } rd_state_t;

endpackage

`default_nettype wire

/* design/frame_write_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_write_ctrl
   import resizer_pixel_pkg::*, resizer_frame_pkg::*;
(
   input  wire logic       i_clk,
   input  wire logic       i_rstn,
   input  wire logic       i_s_tvalid,
   input  wire stream_in_t i_s_tdata,
   output logic            o_s_tready,
   input  wire rows_t      i_rows_retired,
   input  wire logic       i_frame_done,
   output logic            o_wr_en,
   output x_t              o_wr_x,
   output slot_t           o_wr_slot,
   output pixel_t          o_wr_pixel,
   output logic            o_row_done
);

   wr_state_t state;
   x_t        wr_x;
   y_t        wr_y;
   logic      accept;
   logic      last_x;
   logic      last_y;
   pixel_t    pix;

   // stall once the buffer is four rows ahead of the reader
   assign o_s_tready = (state == WR_ACCEPT) &&
                       (rows_t'(wr_y) < i_rows_retired + rows_t'(WIN));
   assign accept     = i_s_tvalid && o_s_tready;
   assign last_x     = (wr_x == x_t'(FRAME_W - 1));
   assign last_y     = (wr_y == y_t'(FRAME_H - 1));

   assign pix.r = i_s_tdata.tdata[7:0];
   assign pix.g = i_s_tdata.tdata[15:8];
   assign pix.b = i_s_tdata.tdata[23:16];

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         state <= WR_IDLE;
         wr_x  <= '0;
         wr_y  <= '0;
      end else begin
         case (state)
            WR_IDLE: begin
               state <= WR_ACCEPT;
            end
            WR_ACCEPT: begin
               if (accept && last_x && last_y) begin
                  state <= WR_HOLD;   // wait for reader to drain frame
               end
            end
            WR_HOLD: begin
               if (i_frame_done) begin
                  state <= WR_ACCEPT;
               end
            end
            default: begin
               state <= WR_IDLE;
            end
         endcase
         if (accept) begin
            if (last_x) begin
               wr_x <= '0;
               wr_y <= last_y ? '0 : wr_y + 1'b1;
            end else begin
               wr_x <= wr_x + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_wr_en    <= 1'b0;
         o_row_done <= 1'b0;
      end else begin
         o_wr_en    <= accept;
         o_row_done <= accept && last_x;
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_wr_x     <= wr_x;
         o_wr_slot  <= slot_t'(wr_y);
         o_wr_pixel <= pix;
      end
   end

   // reader only finishes a frame that was fully written
   a_done_while_held: assert property (@(posedge i_clk) disable iff (!i_rstn)
      i_frame_done |-> (state == WR_HOLD));

endmodule

`default_nettype wire

/* design/line_store.sv */
`timescale 1ns/1ns
`default_nettype none

module line_store
   import resizer_pixel_pkg::*, resizer_frame_pkg::*;
(
   input  wire logic            i_clk,
   input  wire logic            i_rstn,
   input  wire logic            i_clear,
   input  wire logic            i_wr_en,
   input  wire x_t              i_wr_x,
   input  wire slot_t           i_wr_slot,
   input  wire pixel_t          i_wr_pixel,
   input  wire logic            i_row_done,
   input  wire logic            i_rd_en,
   input  wire x_t              i_rd_x,
   input  wire slot_t [WIN-1:0] i_rd_slots,
   output col_t                 o_rd_col,
   output logic                 o_rd_valid,
   output rows_t                o_rows_written
);

   pixel_t mem [WIN][FRAME_W];   // circular, row n lives in slot n mod 4
   logic   rd_wr_hit;

   always_ff @(posedge i_clk) begin
      if (i_wr_en) begin
         mem[i_wr_slot][i_wr_x] <= i_wr_pixel;
      end
   end

   //////////////////////////////
   // column read port
   //////////////////////////////
   always_ff @(posedge i_clk) begin
      if (i_rd_en) begin
         for (int i = 0; i < WIN; i++) begin
            o_rd_col.row[i] <= mem[i_rd_slots[i]][i_rd_x];   // holds until next read
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_rd_valid <= 1'b0;
      end else begin
         o_rd_valid <= i_rd_en;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn || i_clear) begin
         o_rows_written <= '0;
      end else if (i_row_done) begin
         o_rows_written <= o_rows_written + 1'b1;
      end
   end

   always_comb begin
      rd_wr_hit = 1'b0;
      for (int i = 0; i < WIN; i++) begin
         if (i_rd_slots[i] == i_wr_slot && i_rd_x == i_wr_x) begin
            rd_wr_hit = 1'b1;
         end
      end
   end

   // writer flow control must keep the reader's rows untouched
   a_no_rw_collision: assert property (@(posedge i_clk) disable iff (!i_rstn)
      !(i_wr_en && i_rd_en && rd_wr_hit));

endmodule

`default_nettype wire

/* design/window_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module window_reader
   import resizer_pixel_pkg::*, resizer_frame_pkg::*;
(
   input  wire logic       i_clk,
   input  wire logic       i_rstn,
   input  wire rows_t      i_rows_written,
   output logic            o_rd_en,
   output x_t              o_rd_x,
   output slot_t [WIN-1:0] o_rd_slots,
   input  wire col_t       i_rd_col,
   input  wire logic       i_rd_valid,
   output logic            o_m_tvalid,
   output window_t         o_m_tdata,
   output logic            o_m_tlast,
   input  wire logic       i_m_tready,
   output rows_t           o_rows_retired,
   output logic            o_frame_done
);

   rd_state_t state;
   y_t        anchor_y;
   x_t        col_q;         // prime column, then anchor column
   rows_t     need_rows;
   logic      last_col;
   logic      last_row;
   logic      want_rd;
   logic      col_avail;
   logic      col_hold;      // returned column not yet consumed
   logic      consume;
   logic      m_hs;
   logic      tag_prime;
   logic      tag_row_end;
   logic      tag_last;
   logic      out_row_end;
   window_t   win_q;
   window_t   win_next;

   assign need_rows = (anchor_y > y_t'(FRAME_H - WIN)) ? rows_t'(FRAME_H) :
                      rows_t'(anchor_y) + rows_t'(WIN);
   assign last_col  = (col_q == x_t'(FRAME_W - 1));
   assign last_row  = (anchor_y == y_t'(FRAME_H - 1));

   //////////////////////////////
   // edge clamp
   //////////////////////////////
   always_comb begin
      rows_t row_y;
      for (int i = 0; i < WIN; i++) begin
         row_y = rows_t'(anchor_y) + rows_t'(i);
         if (row_y > rows_t'(FRAME_H - 1)) begin
            row_y = rows_t'(FRAME_H - 1);   // bottom rows repeat
         end
         o_rd_slots[i] = slot_t'(row_y);
      end
   end

   always_comb begin
      if (state == RD_PRIME) begin
         o_rd_x = col_q;
      end else if (col_q > x_t'(FRAME_W - WIN)) begin
         o_rd_x = x_t'(FRAME_W - 1);
      end else begin
         o_rd_x = col_q + x_t'(WIN - 1);
      end
   end

   //////////////////////////////
   // read stage
   //////////////////////////////
   assign want_rd   = (state == RD_PRIME) || (state == RD_RUN);
   assign col_avail = i_rd_valid || col_hold;
   assign m_hs      = o_m_tvalid && i_m_tready;
   assign consume   = col_avail && (tag_prime || !o_m_tvalid || i_m_tready);
   assign o_rd_en   = want_rd && (!col_avail || consume);

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         state       <= RD_WAIT;
         anchor_y    <= '0;
         col_q       <= '0;
         col_hold    <= 1'b0;
         tag_prime   <= 1'b0;
         tag_row_end <= 1'b0;
         tag_last    <= 1'b0;
      end else begin
         col_hold <= col_avail && !consume;
         if (o_rd_en) begin
            tag_prime   <= (state == RD_PRIME);
            tag_row_end <= (state == RD_RUN) && last_col;
            tag_last    <= (state == RD_RUN) && last_col && last_row;
         end
         case (state)
            RD_WAIT: begin
               if (i_rows_written >= need_rows) begin
                  state <= RD_PRIME;
               end
            end
            RD_PRIME: begin
               if (o_rd_en) begin
                  if (col_q == x_t'(WIN - 2)) begin
                     state <= RD_RUN;
                     col_q <= '0;
                  end else begin
                     col_q <= col_q + 1'b1;
                  end
               end
            end
            RD_RUN: begin
               if (o_rd_en) begin
                  if (last_col) begin
                     col_q <= '0;
                     if (last_row) begin
                        state <= RD_CLEAR;
                     end else begin
                        anchor_y <= anchor_y + 1'b1;
                        state    <= RD_WAIT;
                     end
                  end else begin
                     col_q <= col_q + 1'b1;
                  end
               end
            end
            RD_CLEAR: begin
               if (o_frame_done) begin
                  anchor_y <= '0;
                  state    <= RD_WAIT;
               end
            end
            default: begin
               state <= RD_WAIT;
            end
         endcase
      end
   end

   //////////////////////////////
   // output register
   //////////////////////////////
   always_comb begin
      win_next.col[WIN-1] = i_rd_col;
      for (int j = 0; j < WIN - 1; j++) begin
         win_next.col[j] = win_q.col[j + 1];
      end
   end

   always_ff @(posedge i_clk) begin
      if (consume) begin
         win_q <= win_next;
         if (!tag_prime) begin
            o_m_tdata <= win_next;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_m_tvalid   <= 1'b0;
         o_m_tlast    <= 1'b0;
         out_row_end  <= 1'b0;
         o_frame_done <= 1'b0;
      end else begin
         if (consume && !tag_prime) begin
            o_m_tvalid  <= 1'b1;
            o_m_tlast   <= tag_last;
            out_row_end <= tag_row_end;
         end else if (m_hs) begin
            o_m_tvalid  <= 1'b0;
            o_m_tlast   <= 1'b0;
            out_row_end <= 1'b0;
         end
         o_frame_done <= m_hs && o_m_tlast;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn || o_frame_done) begin
         o_rows_retired <= '0;
      end else if (m_hs && out_row_end) begin
         o_rows_retired <= o_rows_retired + 1'b1;
      end
   end

   a_hold_while_stalled: assert property (@(posedge i_clk) disable iff (!i_rstn)
      o_m_tvalid && !i_m_tready |=> o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tlast));

endmodule

`default_nettype wire

/* design/bicubic_window_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module bicubic_window_gen
   import resizer_pixel_pkg::*, resizer_frame_pkg::*;
(
   input  wire logic       i_clk,
   input  wire logic       i_rstn,
   input  wire logic       i_s_tvalid,
   input  wire stream_in_t i_s_tdata,
   output logic            o_s_tready,
   output logic            o_m_tvalid,
   output window_t         o_m_tdata,
   output logic            o_m_tlast,
   input  wire logic       i_m_tready
);

   logic            wr_en;
   x_t              wr_x;
   slot_t           wr_slot;
   pixel_t          wr_pixel;
   logic            row_done;
   rows_t           rows_written;
   rows_t           rows_retired;
   logic            frame_done;
   logic            rd_en;
   x_t              rd_x;
   slot_t [WIN-1:0] rd_slots;
   col_t            rd_col;
   logic            rd_valid;

   frame_write_ctrl u_write (
      .i_clk          (i_clk),
      .i_rstn         (i_rstn),
      .i_s_tvalid     (i_s_tvalid),
      .i_s_tdata      (i_s_tdata),
      .o_s_tready     (o_s_tready),
      .i_rows_retired (rows_retired),
      .i_frame_done   (frame_done),
      .o_wr_en        (wr_en),
      .o_wr_x         (wr_x),
      .o_wr_slot      (wr_slot),
      .o_wr_pixel     (wr_pixel),
      .o_row_done     (row_done)
   );

   line_store u_lines (
      .i_clk          (i_clk),
      .i_rstn         (i_rstn),
      .i_clear        (frame_done),   // next frame starts empty
      .i_wr_en        (wr_en),
      .i_wr_x         (wr_x),
      .i_wr_slot      (wr_slot),
      .i_wr_pixel     (wr_pixel),
      .i_row_done     (row_done),
      .i_rd_en        (rd_en),
      .i_rd_x         (rd_x),
      .i_rd_slots     (rd_slots),
      .o_rd_col       (rd_col),
      .o_rd_valid     (rd_valid),
      .o_rows_written (rows_written)
   );

   window_reader u_reader (
      .i_clk          (i_clk),
      .i_rstn         (i_rstn),
      .i_rows_written (rows_written),
      .o_rd_en        (rd_en),
      .o_rd_x         (rd_x),
      .o_rd_slots     (rd_slots),
      .i_rd_col       (rd_col),
      .i_rd_valid     (rd_valid),
      .o_m_tvalid     (o_m_tvalid),
      .o_m_tdata      (o_m_tdata),
      .o_m_tlast      (o_m_tlast),
      .i_m_tready     (i_m_tready),
      .o_rows_retired (rows_retired),
      .o_frame_done   (frame_done)
   );

endmodule

`default_nettype wire

/* testbench/window_model.svh */
`ifndef WINDOW_MODEL_SVH
`define WINDOW_MODEL_SVH

localparam int NUM_FRAMES = 3;
localparam int FRAME_PIX  = FRAME_W * FRAME_H;

typedef logic [$bits(window_t)-1:0] chk_t;   // widest value a check compares

pixel_t img [NUM_FRAMES][FRAME_H][FRAME_W];   // every frame as it was sent

// channel order on the input stream is R, G, B from the low byte up
function automatic void store_pixel(input int f, input int y, input int x,
                                    input logic [31:0] word);
   img[f][y][x].r = word[7:0];
   img[f][y][x].g = word[15:8];
   img[f][y][x].b = word[23:16];
endfunction

//////////////////////////////
// reference window
//////////////////////////////
function automatic window_t expected_window(input int f, input int r, input int c);
   window_t w;
   int      ry;
   int      cx;
   for (int j = 0; j < WIN; j++) begin
      cx = c + j;
      if (cx > FRAME_W - 1) begin
         cx = FRAME_W - 1;   // right edge repeats
      end
      for (int i = 0; i < WIN; i++) begin
         ry = r + i;
         if (ry > FRAME_H - 1) begin
            ry = FRAME_H - 1;   // bottom edge repeats
         end
         w.col[j].row[i] = img[f][ry][cx];
      end
   end
   return w;
endfunction

task automatic check_value(input string name, input chk_t got, input chk_t exp);
   if (got !== exp) begin
      fail_run($sformatf("[FAIL] time %0t: %s got %0h expected %0h",
                         $time, name, got, exp));
   end
endtask

`endif

/* testbench/tb_bicubic_window_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_bicubic_window_gen
   import resizer_pixel_pkg::*, resizer_frame_pkg::*;
();

   localparam int unsigned SEED     = 32'he105_81bc;
   localparam int          IDLE_MAX = 2000;   // cycles without a new window

   logic        i_clk;
   logic        i_rstn;
   logic        i_s_tvalid;
   stream_in_t  i_s_tdata;
   logic        o_s_tready;
   logic        o_m_tvalid;
   window_t     o_m_tdata;
   logic        o_m_tlast;
   logic        i_m_tready;

   int          tx_count;
   int          rx_count;
   logic [31:0] tx_word;     // pixel word offered until accepted
   logic        stalled;
   window_t     held_data;
   logic        held_last;

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   `include "window_model.svh"

   bicubic_window_gen DUT (
      .i_clk      (i_clk),
      .i_rstn     (i_rstn),
      .i_s_tvalid (i_s_tvalid),
      .i_s_tdata  (i_s_tdata),
      .o_s_tready (o_s_tready),
      .o_m_tvalid (o_m_tvalid),
      .o_m_tdata  (o_m_tdata),
      .o_m_tlast  (o_m_tlast),
      .i_m_tready (i_m_tready)
   );

   always #50 i_clk = ~i_clk;

   //////////////////////////////
   // per-cycle stimulus
   //////////////////////////////
   task automatic drive_source();
      if (tx_count < NUM_FRAMES * FRAME_PIX) begin
         i_s_tvalid      = (($urandom % 4) != 0);   // random gaps
         i_s_tdata.tdata = tx_word;
         if (i_s_tvalid && o_s_tready) begin
            store_pixel(tx_count / FRAME_PIX, (tx_count / FRAME_W) % FRAME_H,
                        tx_count % FRAME_W, tx_word);
            tx_count++;
            tx_word = $urandom;
         end
      end else begin
         i_s_tvalid = 1'b0;
      end
   endtask

   task automatic take_window();
      int f;
      int r;
      int c;
      f = rx_count / FRAME_PIX;
      r = (rx_count / FRAME_W) % FRAME_H;
      c = rx_count % FRAME_W;
      check_value("o_m_tdata", o_m_tdata, expected_window(f, r, c));
      check_value("o_m_tlast", chk_t'(o_m_tlast),
                  chk_t'(r == FRAME_H - 1 && c == FRAME_W - 1));
      rx_count++;
   endtask

   task automatic drive_sink();
      if (stalled) begin
         check_value("o_m_tvalid", chk_t'(o_m_tvalid), chk_t'(1));
         check_value("o_m_tdata", o_m_tdata, held_data);   // must hold under back-pressure
         check_value("o_m_tlast", chk_t'(o_m_tlast), chk_t'(held_last));
      end
      i_m_tready = (($urandom % 3) != 0);
      stalled    = o_m_tvalid && !i_m_tready;
      held_data  = o_m_tdata;
      held_last  = o_m_tlast;
      if (o_m_tvalid && i_m_tready) begin
         take_window();
      end
   endtask

   initial begin
      int          wait_cycles;
      int          idle;
      int          last_rx;
      i_clk      = 1'b0;
      i_rstn     = 1'b0;
      i_s_tvalid = 1'b0;
      i_s_tdata  = '0;
      i_m_tready = 1'b0;
      tx_count   = 0;
      rx_count   = 0;
      stalled    = 1'b0;
      held_data  = '0;
      held_last  = 1'b0;
      void'($urandom(SEED));
      tx_word    = $urandom;

      repeat (5) begin
         @(negedge i_clk);
         check_value("o_s_tready", chk_t'(o_s_tready), '0);
         check_value("o_m_tvalid", chk_t'(o_m_tvalid), '0);
      end
      i_rstn = 1'b1;

      wait_cycles = 0;
      while (!o_s_tready) begin
         @(negedge i_clk);
         wait_cycles++;
         if (wait_cycles > 20) begin
            fail_run("input ready never rose after reset was released");
         end
      end

      idle    = 0;
      last_rx = 0;
      while (rx_count < NUM_FRAMES * FRAME_PIX) begin
         @(negedge i_clk);
         drive_source();
         drive_sink();
         if (rx_count != last_rx) begin
            idle    = 0;
            last_rx = rx_count;
         end else begin
            idle++;
            if (idle > IDLE_MAX) begin
               fail_run($sformatf("no output window for %0d cycles after %0d windows",
                                  IDLE_MAX, rx_count));
            end
         end
      end

      // no extra windows, and the writer reopens for a new frame
      wait_cycles = 0;
      while (wait_cycles < 20) begin
         @(negedge i_clk);
         i_m_tready = 1'b1;
         check_value("o_m_tvalid", chk_t'(o_m_tvalid), '0);
         wait_cycles++;
      end
      check_value("o_s_tready", chk_t'(o_s_tready), chk_t'(1));

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* bicubic_window_gen.f */
+incdir+testbench
design/resizer_pixel_pkg.sv
design/resizer_frame_pkg.sv
design/frame_write_ctrl.sv
design/line_store.sv
design/window_reader.sv
design/bicubic_window_gen.sv
testbench/tb_bicubic_window_gen.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bicubic window generator testbench with Verilator
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --top-module tb_bicubic_window_gen \
   -f bicubic_window_gen.f -o tb_sim > sim.log 2>&1 &&
./obj_dir/tb_sim >> sim.log 2>&1 ||
echo "SIMULATION FAILED" >> sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed, see sim.log"; exit 1; }
echo "run passed, see sim.log"
exit 0
